// File: verilog/core_pkg.sv
// shared types and constants for the clk_sys control logic
// quirk table holds a representative subset of known serials only
// serials are eight ascii characters, first character in the top byte

package core_pkg;

	// quirk flag bit positions, fifo on top
	localparam int QK_SCHAN  = 0;
	localparam int QK_FMBUSY = 1;
	localparam int QK_SVP    = 2;
	localparam int QK_PIER   = 3;
	localparam int QK_NORAM  = 4;
	localparam int QK_SRAM00 = 5;
	localparam int QK_SRAM   = 6;
	localparam int QK_EEPROM = 7;
	localparam int QK_FIFO   = 8;

	typedef logic [31:0] bus_addr_t;           // bridge address
	typedef logic [31:0] bus_data_t;
	typedef logic [15:0] pad_key_t;            // raw key bitmap
	typedef logic [11:0] pad_joy_t;            // Z Y X mode start B C A up down left right
	typedef logic [24:0] rom_addr_t;           // download byte address
	typedef logic [15:0] rom_word_t;
	typedef logic [63:0] cart_id_t;            // header serial
	typedef logic [QK_FIFO:QK_SCHAN] quirk_t;
	typedef logic [7:0] gun_delay_t;
	typedef logic [3:0] colour4_t;
	typedef logic [23:0] rgb24_t;

	typedef enum logic [1:0] {BK_IDLE, BK_LOAD, BK_SAVE} bk_state_t;

	////////////////////////////////
	// settings bank addresses
	localparam bus_addr_t REG_BORDER       = 32'h00;
	localparam bus_addr_t REG_CRAM_DOTS    = 32'h04;
	localparam bus_addr_t REG_SPRITE_LIMIT = 32'h08;
	localparam bus_addr_t REG_HIFI_PCM     = 32'h10;
	localparam bus_addr_t REG_FM           = 32'h14;

	////////////////////////////////
	// rom header serial location
	localparam rom_addr_t HDR_ID0   = 25'h182;
	localparam rom_addr_t HDR_ID1   = 25'h184;
	localparam rom_addr_t HDR_ID2   = 25'h186;
	localparam rom_addr_t HDR_ID3   = 25'h188;
	localparam rom_addr_t HDR_ID4   = 25'h18A;
	localparam rom_addr_t HDR_MATCH = 25'h18C;   // serial complete here

	localparam gun_delay_t GUN_DELAY_DEFAULT = 8'd44;

	localparam int QUIRK_N = 8;
	localparam cart_id_t QUIRK_IDS [0:QUIRK_N-1] = '{
		"T-081276", "MK-1215 ", "T-113016", "T-89016 ",
		"T-574023", "MK-1229 ", "T-35036 ", " GM 0000"};
	localparam quirk_t QUIRK_BITS [0:QUIRK_N-1] = '{
		quirk_t'(1) << QK_SRAM, quirk_t'(1) << QK_EEPROM,
		quirk_t'(1) << QK_NORAM, quirk_t'(1) << QK_FIFO,
		quirk_t'(1) << QK_PIER, quirk_t'(1) << QK_SVP,
		quirk_t'(1) << QK_FMBUSY, quirk_t'(1) << QK_SRAM00};

	// lightgun timing per title
	localparam int GUN_N = 3;
	localparam cart_id_t GUN_IDS [0:GUN_N-1] = '{"MK-1533 ", "T-95096-", "T-081156"};
	localparam logic GUN_TYPES [0:GUN_N-1] = '{1'b0, 1'b1, 1'b0};
	localparam gun_delay_t GUN_DELAYS [0:GUN_N-1] = '{8'd100, 8'd52, 8'd126};

endpackage

// File: verilog/settings_regs.sv
// core settings written over the bridge, one bit per register
// bit 0 of write data only, exact address match, no readback

`timescale 1ns/1ps

module settings_regs (
	input  logic                clk_sys,
	input  logic                rst_n,
	input  logic                wr,              // single-cycle strobe
	input  core_pkg::bus_addr_t addr,
	input  core_pkg::bus_data_t wr_data,
	output logic                border_en,
	output logic                cram_dots_en,
	output logic                sprite_limit_en,
	output logic                hifi_pcm_en,
	output logic                fm_en
);

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			border_en       <= 1'b0;
			cram_dots_en    <= 1'b0;
			sprite_limit_en <= 1'b1;     // high sprite limit on by default
			hifi_pcm_en     <= 1'b1;
			fm_en           <= 1'b1;
		end else if (wr) begin
			case (addr)
				core_pkg::REG_BORDER:       border_en       <= wr_data[0];
				core_pkg::REG_CRAM_DOTS:    cram_dots_en    <= wr_data[0];
				core_pkg::REG_SPRITE_LIMIT: sprite_limit_en <= wr_data[0];
				core_pkg::REG_HIFI_PCM:     hifi_pcm_en     <= wr_data[0];
				core_pkg::REG_FM:           fm_en           <= wr_data[0];
				default: ;                   // unused address, ignored
			endcase
		end
	end

endmodule

// File: verilog/pad_remap.sv
// four controllers, keys arrive asynchronous to clk_sys
// joy outputs lag the keys by two clocks, no debounce

`timescale 1ns/1ps

module pad_remap (
	input  logic               clk_sys,
	input  logic               rst_n,
	input  core_pkg::pad_key_t key1,
	input  core_pkg::pad_key_t key2,
	input  core_pkg::pad_key_t key3,
	input  core_pkg::pad_key_t key4,
	output core_pkg::pad_joy_t joy1,
	output core_pkg::pad_joy_t joy2,
	output core_pkg::pad_joy_t joy3,
	output core_pkg::pad_joy_t joy4
);

	core_pkg::pad_key_t meta [0:3];    // first sync stage
	core_pkg::pad_key_t sync [0:3];    // second sync stage

	// key bitmap to console pad order
	function automatic core_pkg::pad_joy_t remap(input core_pkg::pad_key_t k);
		return {k[9], k[6], k[8],       // Z Y X
			k[14], k[15],               // mode start
			k[4], k[5], k[7],           // B C A
			k[0], k[1], k[2], k[3]};    // up down left right
	endfunction

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 4; i++) begin
				meta[i] <= '0;
				sync[i] <= '0;
			end
		end else begin
			meta[0] <= key1;
			meta[1] <= key2;
			meta[2] <= key3;
			meta[3] <= key4;
			for (int i = 0; i < 4; i++)
				sync[i] <= meta[i];
		end
	end

	assign joy1 = remap(sync[0]);
	assign joy2 = remap(sync[1]);
	assign joy3 = remap(sync[2]);
	assign joy4 = remap(sync[3]);

endmodule

// File: verilog/cart_probe.sv
// watches the rom download for the header serial and final size
// serial words must arrive before the write at HDR_MATCH
// unknown serials give no quirks and the default gun timing

`timescale 1ns/1ps

module cart_probe (
	input  logic                   clk_sys,
	input  logic                   rst_n,
	input  logic                   dl_active,   // level, whole download
	input  logic                   dl_wr,       // word strobe
	input  core_pkg::rom_addr_t    dl_addr,
	input  core_pkg::rom_word_t    dl_data,
	output core_pkg::quirk_t       quirks,
	output logic                   gun_type,
	output core_pkg::gun_delay_t   gun_delay,
	output core_pkg::rom_addr_t    rom_size
);

	logic                 dl_q;          // dl_active last cycle
	core_pkg::cart_id_t   cart_id;       // serial being assembled
	core_pkg::quirk_t     quirk_hit;
	logic                 gun_hit_type;
	core_pkg::gun_delay_t gun_hit_delay;

	////////////////////////////////
	// table lookup on the current serial
	always_comb begin
		quirk_hit     = '0;
		gun_hit_type  = 1'b0;
		gun_hit_delay = core_pkg::GUN_DELAY_DEFAULT;
		for (int i = 0; i < core_pkg::QUIRK_N; i++) begin
			if (cart_id == core_pkg::QUIRK_IDS[i])
				quirk_hit = quirk_hit | core_pkg::QUIRK_BITS[i];
		end
		for (int j = 0; j < core_pkg::GUN_N; j++) begin
			if (cart_id == core_pkg::GUN_IDS[j]) begin
				gun_hit_type  = core_pkg::GUN_TYPES[j];
				gun_hit_delay = core_pkg::GUN_DELAYS[j];
			end
		end
	end

	// header bytes are big endian, swap within the word
	always_ff @(posedge clk_sys) begin
		if (dl_active && dl_wr) begin
			case (dl_addr)
				core_pkg::HDR_ID0: cart_id[63:56] <= dl_data[15:8];
				core_pkg::HDR_ID1: cart_id[55:40] <= {dl_data[7:0], dl_data[15:8]};
				core_pkg::HDR_ID2: cart_id[39:24] <= {dl_data[7:0], dl_data[15:8]};
				core_pkg::HDR_ID3: cart_id[23:8]  <= {dl_data[7:0], dl_data[15:8]};
				core_pkg::HDR_ID4: cart_id[7:0]   <= dl_data[7:0];
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			dl_q      <= 1'b0;
			quirks    <= '0;
			gun_type  <= 1'b0;
			gun_delay <= core_pkg::GUN_DELAY_DEFAULT;
			rom_size  <= '0;
		end else begin
			dl_q <= dl_active;
			if (dl_active && !dl_q)
				quirks <= '0;                  // new cart, forget old flags
			if (dl_active && dl_wr && dl_addr == core_pkg::HDR_MATCH) begin
				quirks    <= quirk_hit;
				gun_type  <= gun_hit_type;
				gun_delay <= gun_hit_delay;
			end
			if (dl_q && !dl_active)
				rom_size <= dl_addr;           // last address of the stream
		end
	end

endmodule

// File: verilog/backup_sequencer.sv
// battery save transfer, 2**SECTOR_BITS sectors per sequence
// request held until ack rises, next sector issued when ack falls
// load follows the end of a download, not for svp carts
// save queued out of menu and run once the menu opens

`timescale 1ns/1ps

module backup_sequencer #(
	parameter int SECTOR_BITS = 7
) (
	input  logic                   clk_sys,
	input  logic                   rst_n,
	input  logic                   dl_active,
	input  logic                   svp_quirk,
	input  logic                   bk_change,   // save ram was written
	input  logic                   in_menu,
	input  logic                   sd_ack,
	output logic                   sd_rd,
	output logic                   sd_wr,
	output logic                   busy,
	output logic [SECTOR_BITS-1:0] sd_lba
);

	core_pkg::bk_state_t state;
	logic dl_q, change_q, ack_q;       // edge detect history
	logic save_pend;                   // save waiting for menu
	logic load_go, save_go;
	logic change_rise, ack_rise, ack_fall;

	assign load_go     = dl_q && !dl_active && !svp_quirk;
	assign save_go     = save_pend && in_menu;
	assign change_rise = bk_change && !change_q;
	assign ack_rise    = sd_ack && !ack_q;
	assign ack_fall    = ack_q && !sd_ack;
	assign busy        = (state != core_pkg::BK_IDLE);

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			state     <= core_pkg::BK_IDLE;
			dl_q      <= 1'b0;
			change_q  <= 1'b0;
			ack_q     <= 1'b0;
			save_pend <= 1'b0;
			sd_rd     <= 1'b0;
			sd_wr     <= 1'b0;
			sd_lba    <= '0;
		end else begin
			dl_q     <= dl_active;
			change_q <= bk_change;
			ack_q    <= sd_ack;
			if (change_rise && !in_menu)
				save_pend <= 1'b1;
			if (ack_rise) begin
				sd_rd <= 1'b0;                 // host took the request
				sd_wr <= 1'b0;
			end
			case (state)
				core_pkg::BK_IDLE: begin
					if (load_go) begin          // load wins, save stays queued
						state  <= core_pkg::BK_LOAD;
						sd_lba <= '0;
						sd_rd  <= 1'b1;
					end else if (save_go) begin
						state     <= core_pkg::BK_SAVE;
						save_pend <= 1'b0;
						sd_lba    <= '0;
						sd_wr     <= 1'b1;
					end
				end
				default: begin
					if (ack_fall) begin
						if (&sd_lba) begin
							state <= core_pkg::BK_IDLE;  // last sector done
						end else begin
							sd_lba <= sd_lba + 1'b1;
							sd_rd  <= (state == core_pkg::BK_LOAD);
							sd_wr  <= (state == core_pkg::BK_SAVE);
						end
					end
				end
			endcase
		end
	end

endmodule

// File: verilog/video_formatter.sv
// scaler output stage, all outputs one clock behind the inputs
// sync pulses mark rising edges only, polarity of input not checked

`timescale 1ns/1ps

module video_formatter (
	input  logic               clk_sys,
	input  logic               rst_n,
	input  core_pkg::colour4_t red,
	input  core_pkg::colour4_t green,
	input  core_pkg::colour4_t blue,
	input  logic               hs,
	input  logic               vs,
	input  logic               hblank,
	input  logic               vblank,
	output core_pkg::rgb24_t   rgb,
	output logic               de,
	output logic               hs_pulse,
	output logic               vs_pulse
);

	logic hs_q, vs_q;      // previous sync levels
	logic active;

	assign active = !(hblank || vblank);

	// nibble doubled per channel, black in blanking
	always_ff @(posedge clk_sys) begin
		rgb <= active ? {{2{red}}, {2{green}}, {2{blue}}} : '0;
	end

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			de       <= 1'b0;
			hs_q     <= 1'b0;
			vs_q     <= 1'b0;
			hs_pulse <= 1'b0;
			vs_pulse <= 1'b0;
		end else begin
			de       <= active;
			hs_q     <= hs;
			vs_q     <= vs;
			hs_pulse <= hs && !hs_q;   // one clock per edge
			vs_pulse <= vs && !vs_q;
		end
	end

endmodule

// File: verilog/core_shell.sv
// clk_sys control logic around the emulated console
// svp flag from the cart probe blocks the backup load
// sector count set here, 128 sectors at SECTOR_BITS of 7

`timescale 1ns/1ps

module core_shell #(
	parameter int SECTOR_BITS = 7
) (
	input  logic                   clk_sys,
	input  logic                   rst_n,
	// bridge settings
	input  logic                   wr,
	input  core_pkg::bus_addr_t    addr,
	input  core_pkg::bus_data_t    wr_data,
	output logic                   border_en,
	output logic                   cram_dots_en,
	output logic                   sprite_limit_en,
	output logic                   hifi_pcm_en,
	output logic                   fm_en,
	// controllers
	input  core_pkg::pad_key_t     key1,
	input  core_pkg::pad_key_t     key2,
	input  core_pkg::pad_key_t     key3,
	input  core_pkg::pad_key_t     key4,
	output core_pkg::pad_joy_t     joy1,
	output core_pkg::pad_joy_t     joy2,
	output core_pkg::pad_joy_t     joy3,
	output core_pkg::pad_joy_t     joy4,
	// rom download
	input  logic                   dl_active,
	input  logic                   dl_wr,
	input  core_pkg::rom_addr_t    dl_addr,
	input  core_pkg::rom_word_t    dl_data,
	output core_pkg::quirk_t       quirks,
	output logic                   gun_type,
	output core_pkg::gun_delay_t   gun_delay,
	output core_pkg::rom_addr_t    rom_size,
	// backup ram
	input  logic                   bk_change,
	input  logic                   in_menu,
	input  logic                   sd_ack,
	output logic                   sd_rd,
	output logic                   sd_wr,
	output logic                   busy,
	output logic [SECTOR_BITS-1:0] sd_lba,
	// video
	input  core_pkg::colour4_t     red,
	input  core_pkg::colour4_t     green,
	input  core_pkg::colour4_t     blue,
	input  logic                   hs,
	input  logic                   vs,
	input  logic                   hblank,
	input  logic                   vblank,
	output core_pkg::rgb24_t       rgb,
	output logic                   de,
	output logic                   hs_pulse,
	output logic                   vs_pulse
);

	wire svp_quirk = quirks[core_pkg::QK_SVP];   // no battery ram on svp carts

	settings_regs u_settings (
		.clk_sys(clk_sys), .rst_n(rst_n),
		.wr(wr), .addr(addr), .wr_data(wr_data),
		.border_en(border_en), .cram_dots_en(cram_dots_en),
		.sprite_limit_en(sprite_limit_en), .hifi_pcm_en(hifi_pcm_en), .fm_en(fm_en)
	);

	pad_remap u_pads (
		.clk_sys(clk_sys), .rst_n(rst_n),
		.key1(key1), .key2(key2), .key3(key3), .key4(key4),
		.joy1(joy1), .joy2(joy2), .joy3(joy3), .joy4(joy4)
	);

	cart_probe u_probe (
		.clk_sys(clk_sys), .rst_n(rst_n),
		.dl_active(dl_active), .dl_wr(dl_wr), .dl_addr(dl_addr), .dl_data(dl_data),
		.quirks(quirks), .gun_type(gun_type), .gun_delay(gun_delay), .rom_size(rom_size)
	);

	backup_sequencer #(.SECTOR_BITS(SECTOR_BITS)) u_backup (
		.clk_sys(clk_sys), .rst_n(rst_n),
		.dl_active(dl_active), .svp_quirk(svp_quirk),
		.bk_change(bk_change), .in_menu(in_menu), .sd_ack(sd_ack),
		.sd_rd(sd_rd), .sd_wr(sd_wr), .busy(busy), .sd_lba(sd_lba)
	);

	video_formatter u_video (
		.clk_sys(clk_sys), .rst_n(rst_n),
		.red(red), .green(green), .blue(blue),
		.hs(hs), .vs(vs), .hblank(hblank), .vblank(vblank),
		.rgb(rgb), .de(de), .hs_pulse(hs_pulse), .vs_pulse(vs_pulse)
	);

endmodule

// File: verif/core_shell_assert.sv
// concurrent checks bound into core_shell, sampled on clk_sys
// request and pulse checks idle while in reset

`timescale 1ns/1ps

module core_shell_assert (
	input logic clk_sys,
	input logic rst_n,
	input logic sd_rd,
	input logic sd_wr,
	input logic busy,
	input logic hs_pulse,
	input logic vs_pulse
);

	// one sector request at a time
	rd_wr_exclusive: assert property (@(posedge clk_sys) disable iff (!rst_n)
		!(sd_rd && sd_wr)) else $error("sd_rd and sd_wr high together");

	hs_one_cycle: assert property (@(posedge clk_sys) disable iff (!rst_n)
		hs_pulse |=> !hs_pulse) else $error("hs_pulse longer than one cycle");

	vs_one_cycle: assert property (@(posedge clk_sys) disable iff (!rst_n)
		vs_pulse |=> !vs_pulse) else $error("vs_pulse longer than one cycle");

	busy_in_reset: assert property (@(posedge clk_sys)
		!rst_n |-> !busy) else $error("busy high during reset");

endmodule

bind core_shell core_shell_assert u_assert (
	.clk_sys(clk_sys), .rst_n(rst_n), .sd_rd(sd_rd), .sd_wr(sd_wr),
	.busy(busy), .hs_pulse(hs_pulse), .vs_pulse(vs_pulse)
);

// File: verif/core_shell_tb.sv
// testbench for core_shell, random stimulus from a fixed xorshift seed
// inputs change on the rising edge, outputs sampled on the falling edge
// backup transfers expect 128 sectors, the top level default

`timescale 1ns/1ps

module core_shell_tb;

	localparam int LIMIT = 2000;                // cycles allowed per wait

	logic clk_sys, rst_n;
	logic wr;
	core_pkg::bus_addr_t addr;
	core_pkg::bus_data_t wr_data;
	logic border_en, cram_dots_en, sprite_limit_en, hifi_pcm_en, fm_en;
	core_pkg::pad_key_t key1, key2, key3, key4;
	core_pkg::pad_joy_t joy1, joy2, joy3, joy4;
	logic dl_active, dl_wr;
	core_pkg::rom_addr_t dl_addr, rom_size;
	core_pkg::rom_word_t dl_data;
	core_pkg::quirk_t quirks;
	logic gun_type;
	core_pkg::gun_delay_t gun_delay;
	logic bk_change, in_menu, sd_ack, sd_rd, sd_wr, busy;
	logic [6:0] sd_lba;
	core_pkg::colour4_t red, green, blue;
	logic hs, vs, hblank, vblank;
	core_pkg::rgb24_t rgb;
	logic de, hs_pulse, vs_pulse;

	////////////////////////////////
	// reference tables
	localparam core_pkg::cart_id_t QUIRK_SERIALS [0:7] = '{
		"T-081276", "MK-1215 ", "T-113016", "T-89016 ",
		"T-574023", "MK-1229 ", "T-35036 ", " GM 0000"};
	localparam int QUIRK_POS [0:7] = '{
		core_pkg::QK_SRAM, core_pkg::QK_EEPROM, core_pkg::QK_NORAM, core_pkg::QK_FIFO,
		core_pkg::QK_PIER, core_pkg::QK_SVP, core_pkg::QK_FMBUSY, core_pkg::QK_SRAM00};
	localparam core_pkg::cart_id_t GUN_SERIALS [0:2] = '{"MK-1533 ", "T-95096-", "T-081156"};
	localparam logic [8:0] GUN_EXP [0:2] = '{{1'b0, 8'd100}, {1'b1, 8'd52}, {1'b0, 8'd126}};
	localparam int JOY_SRC [0:11] = '{3, 2, 1, 0, 7, 5, 4, 15, 14, 8, 6, 9};  // right first
	localparam core_pkg::bus_addr_t ADDR_POOL [0:6] = '{
		32'h00, 32'h04, 32'h08, 32'h10, 32'h14, 32'h0C, 32'h18};   // last two unused

	logic [31:0] rng;
	int checks, errors, timeouts;
	logic [4:0] set_exp;                           // fm hifi sprite cram border
	core_pkg::pad_key_t keys_d1 [0:3];             // keys one drive back
	core_pkg::pad_key_t keys_d2 [0:3];
	logic [15:0] vid_d1, vid_d2;                   // r g b hs vs hblank vblank

	core_shell dut (.*);

	initial begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys;
	end

	function automatic logic [31:0] rand32();
		logic [31:0] x;
		x = rng;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rng = x;
		return x;
	endfunction

	function automatic core_pkg::pad_joy_t joy_of(input core_pkg::pad_key_t k);
		core_pkg::pad_joy_t j;
		for (int b = 0; b < 12; b++)
			j[b] = k[JOY_SRC[b]];
		return j;
	endfunction

	function automatic core_pkg::quirk_t quirks_of(input core_pkg::cart_id_t id);
		core_pkg::quirk_t q;
		q = '0;
		for (int i = 0; i < 8; i++)
			if (id == QUIRK_SERIALS[i])
				q[QUIRK_POS[i]] = 1'b1;
		return q;
	endfunction

	function automatic logic [8:0] gun_of(input core_pkg::cart_id_t id);   // type, delay
		logic [8:0] g;
		g = {1'b0, 8'd44};                            // unknown title
		for (int i = 0; i < 3; i++)
			if (id == GUN_SERIALS[i])
				g = GUN_EXP[i];
		return g;
	endfunction

	function automatic core_pkg::cart_id_t pick_serial(input logic [31:0] r);
		int sel;
		sel = int'(r % 12);
		if (sel < 8)
			return QUIRK_SERIALS[sel];
		if (sel < 11)
			return GUN_SERIALS[sel - 8];
		return {rand32(), rand32()};                  // serial not in any table
	endfunction

	// header words big endian, serial from the top byte down
	function automatic core_pkg::rom_word_t word_at(input core_pkg::rom_addr_t a,
			input core_pkg::cart_id_t id, input logic [31:0] fill);
		case (a)
			core_pkg::HDR_ID0: return {id[63:56], fill[7:0]};
			core_pkg::HDR_ID1: return {id[47:40], id[55:48]};
			core_pkg::HDR_ID2: return {id[31:24], id[39:32]};
			core_pkg::HDR_ID3: return {id[15:8], id[23:16]};
			core_pkg::HDR_ID4: return {fill[15:8], id[7:0]};
			default: return fill[15:0];
		endcase
	endfunction

	function automatic core_pkg::rgb24_t rgb_of(input logic [15:0] v);
		if (v[1] || v[0])
			return '0;                                  // blanking
		return {v[15:12] * 8'h11, v[11:8] * 8'h11, v[7:4] * 8'h11};
	endfunction

	task automatic compare_value(input string name, input logic [63:0] got,
			input logic [63:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED %s got %0h expected %0h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic finish_run();
		$display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	endtask

	task automatic give_up(input string what);
		$display("timeout: %s within %0d cycles", what, LIMIT);
		timeouts++;
		finish_run();
	endtask

	// 0 request up, 1 request down, 2 sequencer idle
	function automatic logic reached(input int goal);
		case (goal)
			0: return sd_rd || sd_wr;
			1: return !(sd_rd || sd_wr);
			default: return !busy;
		endcase
	endfunction

	task automatic wait_for(input int goal, input string what);
		int n;
		n = 0;
		@(negedge clk_sys);
		while (!reached(goal)) begin
			if (n == LIMIT)
				give_up(what);
			n++;
			@(negedge clk_sys);
		end
	endtask

	task automatic expect_quiet(input int cycles);
		repeat (cycles) begin
			@(negedge clk_sys);
			compare_value("sd_rd", sd_rd, 0);
			compare_value("sd_wr", sd_wr, 0);
			compare_value("busy", busy, 0);
		end
	endtask

	////////////////////////////////
	// host side of the sector handshake
	task automatic serve_backup(input logic is_load);
		for (int s = 0; s < 128; s++) begin
			wait_for(0, "backup request did not arrive");
			compare_value("sd_rd", sd_rd, is_load);
			compare_value("sd_wr", sd_wr, !is_load);
			compare_value("sd_lba", sd_lba, s);
			compare_value("busy", busy, 1);
			repeat (1 + rand32() % 4) @(posedge clk_sys);
			sd_ack <= 1'b1;
			wait_for(1, "request still high after the ack");
			repeat (1 + rand32() % 4) @(posedge clk_sys);
			sd_ack <= 1'b0;                              // next sector or done
		end
		wait_for(2, "busy stayed high after the last ack");
		compare_value("sd_rd", sd_rd, 0);
		compare_value("sd_wr", sd_wr, 0);
	endtask

	task automatic run_download(input core_pkg::cart_id_t id);
		int words;
		core_pkg::rom_addr_t a;
		core_pkg::quirk_t q;
		logic [8:0] g;
		words = 200 + int'(rand32() % 64);             // always past HDR_MATCH
		q = quirks_of(id);
		g = gun_of(id);
		a = '0;
		@(posedge clk_sys);
		dl_active <= 1'b1;
		for (int w = 0; w < words; w++) begin
			@(posedge clk_sys);
			a = core_pkg::rom_addr_t'(2 * w);
			dl_wr <= 1'b1;
			dl_addr <= a;
			dl_data <= word_at(a, id, rand32());
		end
		@(posedge clk_sys);
		dl_wr <= 1'b0;
		dl_active <= 1'b0;                             // dl_addr keeps the last address
		@(posedge clk_sys);
		@(negedge clk_sys);
		compare_value("rom_size", rom_size, a);
		compare_value("quirks", quirks, q);
		compare_value("gun_type", gun_type, g[8]);
		compare_value("gun_delay", gun_delay, g[7:0]);
		if (q[core_pkg::QK_SVP])
			expect_quiet(16);                            // svp carts skip the load
		else
			serve_backup(1'b1);
	endtask

	// settings strobes, pad keys and video inputs every cycle
	task automatic random_traffic(input int cycles);
		logic [31:0] r;
		logic [31:0] d;
		core_pkg::bus_addr_t a;
		core_pkg::pad_key_t k [0:3];
		logic [15:0] v;
		for (int i = 0; i < cycles; i++) begin
			r = rand32();
			d = rand32();
			a = (r[2:0] == 3'd7) ? rand32() : ADDR_POOL[r[2:0]];
			for (int c = 0; c < 4; c++)
				k[c] = core_pkg::pad_key_t'(rand32());
			v = 16'(rand32());
			@(posedge clk_sys);
			wr <= r[3];
			addr <= a;
			wr_data <= d;
			key1 <= k[0];
			key2 <= k[1];
			key3 <= k[2];
			key4 <= k[3];
			{red, green, blue, hs, vs, hblank, vblank} <= v;
			@(negedge clk_sys);
			if (i > 0) begin
				compare_value("settings", {fm_en, hifi_pcm_en, sprite_limit_en,
					cram_dots_en, border_en}, set_exp);
				compare_value("joy1", joy1, joy_of(keys_d2[0]));
				compare_value("joy2", joy2, joy_of(keys_d2[1]));
				compare_value("joy3", joy3, joy_of(keys_d2[2]));
				compare_value("joy4", joy4, joy_of(keys_d2[3]));
				compare_value("rgb", rgb, rgb_of(vid_d1));
				compare_value("de", de, !(vid_d1[1] || vid_d1[0]));
				compare_value("hs_pulse", hs_pulse, vid_d1[3] && !vid_d2[3]);
				compare_value("vs_pulse", vs_pulse, vid_d1[2] && !vid_d2[2]);
			end
			if (r[3]) begin
				case (a)
					32'h00: set_exp[0] = d[0];
					32'h04: set_exp[1] = d[0];
					32'h08: set_exp[2] = d[0];
					32'h10: set_exp[3] = d[0];
					32'h14: set_exp[4] = d[0];
					default: ;                               // unused address
				endcase
			end
			keys_d2 = keys_d1;
			keys_d1 = k;
			vid_d2 = vid_d1;
			vid_d1 = v;
		end
		@(posedge clk_sys);
		wr <= 1'b0;
	endtask

	initial begin
		rng = 32'h6b8055f0;
		checks = 0;
		errors = 0;
		timeouts = 0;
		set_exp = 5'b11100;                            // reset defaults
		for (int c = 0; c < 4; c++) begin
			keys_d1[c] = '0;
			keys_d2[c] = '0;
		end
		vid_d1 = '0;
		vid_d2 = '0;
		rst_n = 1'b0;
		{wr, addr, wr_data} = '0;
		{key1, key2, key3, key4} = '0;
		{dl_active, dl_wr, dl_addr, dl_data} = '0;
		{bk_change, in_menu, sd_ack} = '0;
		{red, green, blue, hs, vs, hblank, vblank} = '0;
		repeat (3) @(posedge clk_sys);
		rst_n <= 1'b1;
		@(negedge clk_sys);
		compare_value("settings", {fm_en, hifi_pcm_en, sprite_limit_en,
			cram_dots_en, border_en}, set_exp);
		compare_value("quirks", quirks, 0);
		compare_value("sd_rd", sd_rd, 0);
		compare_value("sd_wr", sd_wr, 0);
		compare_value("busy", busy, 0);
		compare_value("de", de, 0);
		compare_value("hs_pulse", hs_pulse, 0);
		compare_value("vs_pulse", vs_pulse, 0);
		random_traffic(400);
		for (int n = 0; n < 7; n++) begin
			if (n == 2)
				run_download(QUIRK_SERIALS[5]);           // svp title
			else if (n == 4)
				run_download(GUN_SERIALS[1]);
			else
				run_download(pick_serial(rand32()));
		end
		// save queued outside the menu
		@(posedge clk_sys);
		bk_change <= 1'b1;
		@(posedge clk_sys);
		bk_change <= 1'b0;
		expect_quiet(1 + int'(rand32() % 8));
		@(posedge clk_sys);
		in_menu <= 1'b1;
		serve_backup(1'b0);
		// change inside the menu queues nothing
		@(posedge clk_sys);
		bk_change <= 1'b1;
		@(posedge clk_sys);
		bk_change <= 1'b0;
		expect_quiet(16);
		@(posedge clk_sys);
		in_menu <= 1'b0;
		expect_quiet(8);
		finish_run();
	end

endmodule

// File: build.f
verilog/core_pkg.sv
verilog/settings_regs.sv
verilog/pad_remap.sv
verilog/cart_probe.sv
verilog/backup_sequencer.sv
verilog/video_formatter.sv
verilog/core_shell.sv
verif/core_shell_assert.sv
verif/core_shell_tb.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = core_shell_tb
FILELIST = build.f
LOG      = sim.log
FAIL_MSG = *** TEST FAILED ***

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -qF '$(FAIL_MSG)' $(LOG); then \
		echo "simulation failed"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
